// File: hdl/dma_config.svh
// Flit layout, header field positions, request table size and buffer depth
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

////////////////////
// Flit layout
////////////////////

// Two flit type bits above 32 content bits
`define DMA_FLIT_WIDTH    34
`define DMA_FLIT_TYPE_MSB 33
`define DMA_FLIT_TYPE_LSB 32
`define DMA_CONTENT_MSB   31
`define DMA_CONTENT_LSB   0

////////////////////
// Header fields
////////////////////

// Positions inside the content of a header flit
`define DMA_PKT_TYPE_MSB  12
`define DMA_PKT_TYPE_LSB  11
`define DMA_PKT_ID_MSB    18
`define DMA_PKT_ID_LSB    17
// Set on the final response packet of a request
`define DMA_PKT_RESP_LAST 19

////////////////////
// Sizes
////////////////////

`define DMA_TABLE_ENTRIES 4
// Power of two
`define DMA_BUF_DEPTH     16

`endif

// File: hdl/dma_noc_pkg.sv
// NoC side types: flit, flit type, packet type and request table slot id
`include "dma_config.svh"

package dma_noc_pkg;

  ////////////////////
  // Flits
  ////////////////////

  // Type bits on top, content below
  typedef logic [`DMA_FLIT_WIDTH-1:0] flit_t;

  // Flit position within a packet
  typedef enum logic [1:0] {
    FLIT_MIDDLE = 2'b00,
    FLIT_HEADER = 2'b01,
    FLIT_LAST   = 2'b10,
    // Header and last in one flit
    FLIT_SINGLE = 2'b11
  } flit_type_e;

  ////////////////////
  // Packets
  ////////////////////

  // Response kinds seen on the receive side
  typedef enum logic [1:0] {
    PKT_OTHER    = 2'b00,
    PKT_L2R_RESP = 2'b10,
    PKT_R2L_RESP = 2'b11
  } pkt_type_e;

  // Index into the request table
  typedef logic [$clog2(`DMA_TABLE_ENTRIES)-1:0] slot_id_t;

endpackage

// File: hdl/dma_bus_pkg.sv
// Bus side types: address, data word and AHB-Lite transfer and burst encodings
package dma_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // AHB transfer types, BUSY never issued
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Only single and undefined length incrementing bursts
  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001
  } hburst_e;

  // 32 bit transfers only
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Privileged data access, not bufferable or cacheable
  localparam logic [3:0] HPROT_DATA = 4'b0011;

endpackage

// File: hdl/dma_packet_buffer.sv
// Flit FIFO with a registered head stage between the NoC input and the parser
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_packet_buffer
  import dma_noc_pkg::*;
#(
  parameter int DEPTH = `DMA_BUF_DEPTH
) (
  input  logic  clk,
  input  logic  rst,
  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,
  output flit_t out_flit,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage behind the head register, never more than DEPTH-1 used
  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Total occupancy, head register included
  logic [CNT_W-1:0] count;
  flit_t            head_q;
  logic             head_valid;
  logic             push;
  logic             pop;
  logic             load;
  logic             mem_empty;
  logic             bypass;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign push      = in_valid && in_ready;
  assign pop       = head_valid && out_ready;
  // Pointers only meet when storage is empty
  assign mem_empty = (rd_ptr == wr_ptr);
  // Head free or leaving this cycle
  assign load      = !head_valid || pop;
  // Straight into the head when nothing is queued
  assign bypass    = load && mem_empty && push;

  assign out_flit  = head_q;
  assign out_valid = head_valid;

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (push && !bypass) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  // Oldest queued flit has priority over the incoming one
  always_ff @(posedge clk) begin
    if (load) begin
      if (!mem_empty) begin
        head_q <= mem[rd_ptr];
      end else if (push) begin
        head_q <= in_flit;
      end
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      head_valid <= 1'b0;
    end else begin
      if (push && !bypass) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (load && !mem_empty) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      if (load) begin
        head_valid <= !mem_empty || push;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

// File: hdl/dma_resp_parser.sv
// Response parser FSM turning data flits into write beats and L2R headers into notify tokens
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_resp_parser
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  flit_t    buf_flit,
  input  logic     buf_valid,
  output logic     buf_ready,
  output logic     beat_valid,
  input  logic     beat_ready,
  output addr_t    beat_addr,
  output word_t    beat_data,
  output logic     beat_first,
  output logic     beat_write,
  output logic     beat_done,
  output slot_id_t beat_done_id
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_GET_SIZE,
    ST_GET_ADDR,
    ST_DATA
  } state_e;

  state_e     state;
  state_e     state_nxt;
  // Latched from the header
  slot_id_t   id_q;
  logic       resp_last_q;
  // Next write address
  addr_t      addr_q;
  logic       first_q;
  flit_type_e flit_type;
  pkt_type_e  pkt_type;
  logic       is_header;
  logic       is_last;
  logic       take;

  assign flit_type = flit_type_e'(buf_flit[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB]);
  assign pkt_type  = pkt_type_e'(buf_flit[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]);
  assign is_header = (flit_type == FLIT_HEADER) || (flit_type == FLIT_SINGLE);
  assign is_last   = (flit_type == FLIT_LAST) || (flit_type == FLIT_SINGLE);
  assign take      = buf_valid && buf_ready;

  assign beat_addr  = addr_q;
  assign beat_data  = word_t'(buf_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB]);
  assign beat_first = first_q;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_nxt    = state;
    buf_ready    = 1'b0;
    beat_valid   = 1'b0;
    beat_write   = 1'b1;
    beat_done    = 1'b0;
    beat_done_id = id_q;
    case (state)
      ST_IDLE: begin
        if (buf_valid && is_header && (pkt_type == PKT_L2R_RESP)) begin
          // Ack only, completion token straight from the head flit
          beat_valid   = 1'b1;
          beat_write   = 1'b0;
          beat_done    = 1'b1;
          beat_done_id = slot_id_t'(buf_flit[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]);
          buf_ready    = beat_ready;
        end else begin
          // Stray payload flits and unknown headers fall through here
          buf_ready = 1'b1;
          if (buf_valid && is_header && (pkt_type == PKT_R2L_RESP)) begin
            state_nxt = ST_GET_SIZE;
          end
        end
      end
      ST_GET_SIZE: begin
        // Length comes from the last flit instead
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_nxt = ST_GET_ADDR;
        end
      end
      ST_GET_ADDR: begin
        buf_ready = 1'b1;
        if (buf_valid) begin
          state_nxt = ST_DATA;
        end
      end
      ST_DATA: begin
        beat_valid = buf_valid;
        beat_done  = is_last && resp_last_q;
        buf_ready  = beat_ready;
        if (take && is_last) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      first_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (take && (state == ST_GET_ADDR)) begin
        first_q <= 1'b1;
      end else if (take && (state == ST_DATA)) begin
        first_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      case (state)
        ST_IDLE: begin
          id_q        <= slot_id_t'(buf_flit[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]);
          resp_last_q <= buf_flit[`DMA_PKT_RESP_LAST];
        end
        ST_GET_ADDR: addr_q <= addr_t'(buf_flit[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB]);
        // Word steps
        ST_DATA:     addr_q <= addr_q + addr_t'(4);
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/dma_ahb_writer.sv
// Pipelined AHB-Lite write master with in-order completion reporting
`timescale 1ns/1ps

module dma_ahb_writer
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       beat_valid,
  output logic       beat_ready,
  input  addr_t      beat_addr,
  input  word_t      beat_data,
  input  logic       beat_first,
  input  logic       beat_write,
  input  logic       beat_done,
  input  slot_id_t   beat_done_id,
  output logic       hsel,
  output addr_t      haddr,
  output htrans_e    htrans,
  output logic       hwrite,
  output logic [2:0] hsize,
  output hburst_e    hburst,
  output logic [3:0] hprot,
  output word_t      hwdata,
  input  logic       hready,
  output logic       done_en,
  output slot_id_t   done_pos
);

  // Address phase stage
  logic     ap_valid;
  addr_t    ap_addr;
  word_t    ap_data;
  logic     ap_first;
  logic     ap_done;
  slot_id_t ap_id;
  // Data phase stage
  logic     dp_valid;
  word_t    dp_data;
  logic     dp_done;
  slot_id_t dp_id;
  logic     ap_free;
  logic     write_take;
  logic     notify_take;
  logic     dp_retire;

  // Address slot empty or handing over on this edge
  assign ap_free     = !ap_valid || hready;
  // Tokens wait for both stages to drain
  assign beat_ready  = beat_write ? ap_free : (!ap_valid && !dp_valid);
  assign write_take  = beat_valid && beat_write && ap_free;
  assign notify_take = beat_valid && !beat_write && !ap_valid && !dp_valid;
  assign dp_retire   = dp_valid && hready;

  ////////////////////
  // Bus outputs
  ////////////////////

  assign hsel   = ap_valid;
  assign haddr  = ap_addr;
  assign hwrite = ap_valid;
  assign hsize  = HSIZE_WORD;
  assign hprot  = HPROT_DATA;
  assign hwdata = dp_data;

  // NONSEQ opens each packet, SEQ for the rest
  always_comb begin
    if (!ap_valid) begin
      htrans = HTRANS_IDLE;
      hburst = HBURST_SINGLE;
    end else begin
      htrans = ap_first ? HTRANS_NONSEQ : HTRANS_SEQ;
      hburst = HBURST_INCR;
    end
  end

  ////////////////////
  // Pipeline
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ap_valid <= 1'b0;
      dp_valid <= 1'b0;
      done_en  <= 1'b0;
    end else begin
      if (write_take) begin
        ap_valid <= 1'b1;
      end else if (hready) begin
        ap_valid <= 1'b0;
      end
      // Both phases advance on the same hready
      if (hready) begin
        dp_valid <= ap_valid;
      end
      done_en <= (dp_retire && dp_done) || notify_take;
    end
  end

  always_ff @(posedge clk) begin
    if (write_take) begin
      ap_addr  <= beat_addr;
      ap_data  <= beat_data;
      ap_first <= beat_first;
      ap_done  <= beat_done;
      ap_id    <= beat_done_id;
    end
    if (hready) begin
      dp_data <= ap_data;
      dp_done <= ap_done;
      dp_id   <= ap_id;
    end
    // Never both, a token needs an empty data stage
    if (notify_take) begin
      done_pos <= beat_done_id;
    end else if (dp_retire) begin
      done_pos <= dp_id;
    end
  end

endmodule

// File: hdl/dma_resp_top.sv
// Receive side top level: packet buffer, response parser and AHB write master
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_resp_top
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  flit_t      noc_flit,
  input  logic       noc_valid,
  output logic       noc_ready,
  output logic       hsel,
  output addr_t      haddr,
  output htrans_e    htrans,
  output logic       hwrite,
  output logic [2:0] hsize,
  output hburst_e    hburst,
  output logic [3:0] hprot,
  output word_t      hwdata,
  input  logic       hready,
  output logic       done_en,
  output slot_id_t   done_pos
);

  // Buffer to parser
  flit_t    buf_flit;
  logic     buf_valid;
  logic     buf_ready;
  // Parser to writer
  logic     beat_valid;
  logic     beat_ready;
  addr_t    beat_addr;
  word_t    beat_data;
  logic     beat_first;
  logic     beat_write;
  logic     beat_done;
  slot_id_t beat_done_id;

  dma_packet_buffer #(
    .DEPTH(`DMA_BUF_DEPTH)
  ) u_buffer (
    .clk      (clk),
    .rst      (rst),
    .in_flit  (noc_flit),
    .in_valid (noc_valid),
    .in_ready (noc_ready),
    .out_flit (buf_flit),
    .out_valid(buf_valid),
    .out_ready(buf_ready)
  );

  dma_resp_parser u_parser (
    .clk         (clk),
    .rst         (rst),
    .buf_flit    (buf_flit),
    .buf_valid   (buf_valid),
    .buf_ready   (buf_ready),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .beat_addr   (beat_addr),
    .beat_data   (beat_data),
    .beat_first  (beat_first),
    .beat_write  (beat_write),
    .beat_done   (beat_done),
    .beat_done_id(beat_done_id)
  );

  dma_ahb_writer u_writer (
    .clk         (clk),
    .rst         (rst),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .beat_addr   (beat_addr),
    .beat_data   (beat_data),
    .beat_first  (beat_first),
    .beat_write  (beat_write),
    .beat_done   (beat_done),
    .beat_done_id(beat_done_id),
    .hsel        (hsel),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hsize       (hsize),
    .hburst      (hburst),
    .hprot       (hprot),
    .hwdata      (hwdata),
    .hready      (hready),
    .done_en     (done_en),
    .done_pos    (done_pos)
  );

endmodule

// File: tests/dma_ahb_mem_model.sv
// AHB-Lite slave memory with random wait states and a write log
`timescale 1ns/1ps

module dma_ahb_mem_model
  import dma_bus_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    hsel,
  input  addr_t   haddr,
  input  htrans_e htrans,
  input  logic    hwrite,
  input  word_t   hwdata,
  input  logic    slow,
  output logic    hready,
  output logic    log_valid,
  output addr_t   log_addr,
  output word_t   log_data
);

  // Write whose data phase is owed
  logic  dp_valid;
  addr_t dp_addr;

  // One wait state draw, mostly stalls in slow mode
  function automatic logic draw_ready(input logic slow_mode);
    int unsigned r;
    r = $urandom % 4;
    return slow_mode ? (r == 0) : (r != 0);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      hready    <= 1'b1;
      dp_valid  <= 1'b0;
      log_valid <= 1'b0;
    end else begin
      log_valid <= 1'b0;
      if (hready) begin
        // Data phase ends here
        if (dp_valid) begin
          log_valid <= 1'b1;
          log_addr  <= dp_addr;
          log_data  <= hwdata;
        end
        // Capture the next address phase
        dp_valid <= hsel && hwrite && (htrans != HTRANS_IDLE);
        dp_addr  <= haddr;
        if (hsel && hwrite && (htrans != HTRANS_IDLE)) begin
          hready <= draw_ready(slow);
        end else begin
          hready <= 1'b1;
        end
      end else begin
        // Still stretching the data phase
        hready <= draw_ready(slow);
      end
    end
  end

endmodule

// File: tests/tb_dma_resp.sv
// Testbench for the DMA receive path: clock, reset, packet driver and checks
`timescale 1ns/1ps
`include "dma_config.svh"

module tb_dma_resp
  import dma_noc_pkg::*;
  import dma_bus_pkg::*;
();

  localparam int unsigned SEED       = 32'hd4e0_771a;
  localparam int          WAIT_LIMIT = 2000;

  logic       clk;
  logic       rst;
  flit_t      noc_flit;
  logic       noc_valid;
  logic       noc_ready;
  logic       hsel;
  addr_t      haddr;
  htrans_e    htrans;
  logic       hwrite;
  logic [2:0] hsize;
  hburst_e    hburst;
  logic [3:0] hprot;
  word_t      hwdata;
  logic       hready;
  logic       done_en;
  slot_id_t   done_pos;
  logic       slow;
  logic       log_valid;
  addr_t      log_addr;
  word_t      log_data;

  // Address phases in issue order
  addr_t      bus_addr_q [$];
  logic       bus_first_q [$];
  // Writes and completions in the order they must appear
  logic       ev_done_q [$];
  addr_t      ev_addr_q [$];
  word_t      ev_data_q [$];
  slot_id_t   ev_id_q [$];
  // Head event and address phase being checked
  logic       e_done;
  addr_t      e_addr;
  word_t      e_data;
  slot_id_t   e_id;
  addr_t      exp_haddr;
  logic       exp_first;
  // Last cycle's address phase, for the stall check
  logic       prev_stall;
  addr_t      prev_haddr;
  htrans_e    prev_htrans;
  hburst_e    prev_hburst;
  logic       gaps_on;
  logic       saw_full;
  int unsigned seed_draw;
  int         i;

  dma_resp_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .noc_flit (noc_flit),
    .noc_valid(noc_valid),
    .noc_ready(noc_ready),
    .hsel     (hsel),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hsize    (hsize),
    .hburst   (hburst),
    .hprot    (hprot),
    .hwdata   (hwdata),
    .hready   (hready),
    .done_en  (done_en),
    .done_pos (done_pos)
  );

  dma_ahb_mem_model u_mem (
    .clk      (clk),
    .rst      (rst),
    .hsel     (hsel),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .slow     (slow),
    .hready   (hready),
    .log_valid(log_valid),
    .log_addr (log_addr),
    .log_data (log_data)
  );

  always #20 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic end_in_failure(input string line);
    $display("%s", line);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  function automatic flit_t header_flit(input flit_type_e ftype, input pkt_type_e ptype,
                                        input slot_id_t id, input logic last);
    flit_t f;
    f = '0;
    f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] = ftype;
    f[`DMA_PKT_TYPE_MSB:`DMA_PKT_TYPE_LSB]   = ptype;
    f[`DMA_PKT_ID_MSB:`DMA_PKT_ID_LSB]       = id;
    f[`DMA_PKT_RESP_LAST]                    = last;
    return f;
  endfunction

  function automatic flit_t body_flit(input flit_type_e ftype, input logic [31:0] content);
    flit_t f;
    f = '0;
    f[`DMA_FLIT_TYPE_MSB:`DMA_FLIT_TYPE_LSB] = ftype;
    f[`DMA_CONTENT_MSB:`DMA_CONTENT_LSB]     = content;
    return f;
  endfunction

  function automatic void push_event(input logic done, input addr_t a, input word_t d,
                                     input slot_id_t id);
    ev_done_q.push_back(done);
    ev_addr_q.push_back(a);
    ev_data_q.push_back(d);
    ev_id_q.push_back(id);
  endfunction

  function automatic void take_event();
    e_done = ev_done_q.pop_front();
    e_addr = ev_addr_q.pop_front();
    e_data = ev_data_q.pop_front();
    e_id   = ev_id_q.pop_front();
  endfunction

  // Hold valid until the buffer has room, then one transfer edge
  task automatic drive_flit(input flit_t f);
    int waited;
    int gap;
    waited    = 0;
    noc_flit  = f;
    noc_valid = 1'b1;
    while (!noc_ready) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) end_in_failure("Timeout: noc_ready stayed low too long");
    end
    @(posedge clk);
    #1;
    noc_valid = 1'b0;
    gap = gaps_on ? int'($urandom % 3) : 0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_r2l(input slot_id_t id, input logic last, input addr_t base, input int n);
    word_t data [$];
    word_t w;
    int    k;
    for (k = 0; k < n; k++) begin
      w = $urandom;
      data.push_back(w);
      bus_addr_q.push_back(base + addr_t'(4 * k));
      bus_first_q.push_back(k == 0);
      push_event(1'b0, base + addr_t'(4 * k), w, id);
    end
    if (last) push_event(1'b1, '0, '0, id);
    drive_flit(header_flit(FLIT_HEADER, PKT_R2L_RESP, id, last));
    // Size then start address
    drive_flit(body_flit(FLIT_MIDDLE, n));
    drive_flit(body_flit(FLIT_MIDDLE, base));
    for (k = 0; k < n; k++) begin
      drive_flit(body_flit((k == n - 1) ? FLIT_LAST : FLIT_MIDDLE, data[k]));
    end
  endtask

  task automatic send_l2r(input slot_id_t id);
    push_event(1'b1, '0, '0, id);
    drive_flit(header_flit(FLIT_SINGLE, PKT_L2R_RESP, id, 1'b1));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (ev_done_q.size() != 0 || bus_addr_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) end_in_failure("Timeout: expected writes or completions never came");
    end
  endtask

  ////////////////////
  // Bus and completion monitor
  ////////////////////

  // Mid cycle, all registered outputs settled
  always @(negedge clk) begin
    if (rst) begin
      assert (!done_en && htrans == HTRANS_IDLE && !hsel)
        else end_in_failure($sformatf("Error at %0t: bus or done_en active in reset", $time));
    end else begin
      if (!noc_ready) saw_full = 1'b1;
      if (prev_stall) begin
        assert (haddr == prev_haddr && htrans == prev_htrans && hburst == prev_hburst && hwrite)
          else end_in_failure($sformatf("Error at %0t: address phase moved under a stall, %h",
                                        $time, haddr));
      end
      if (htrans != HTRANS_IDLE) begin
        // Word size, privileged data access
        assert (hsel && hwrite && hburst == HBURST_INCR && hsize == 3'b010 &&
                hprot == 4'b0011)
          else end_in_failure($sformatf("Error at %0t: bad control, hburst %0d hsize %0d hprot %h",
                                        $time, hburst, hsize, hprot));
        if (hready) begin
          assert (bus_addr_q.size() != 0)
            else end_in_failure($sformatf("Error at %0t: extra address phase %h", $time, haddr));
          exp_haddr = bus_addr_q.pop_front();
          exp_first = bus_first_q.pop_front();
          assert (haddr == exp_haddr && htrans == (exp_first ? HTRANS_NONSEQ : HTRANS_SEQ))
            else end_in_failure($sformatf("Error at %0t: haddr %h htrans %0d, expected %h first %0b",
                                          $time, haddr, htrans, exp_haddr, exp_first));
        end
      end
      // A write's log before a completion in the same cycle
      if (log_valid) begin
        assert (ev_done_q.size() != 0)
          else end_in_failure($sformatf("Error at %0t: unexpected write to %h", $time, log_addr));
        take_event();
        assert (!e_done)
          else end_in_failure($sformatf("Error at %0t: write to %h ahead of done for slot %0d",
                                        $time, log_addr, e_id));
        assert (log_addr == e_addr && log_data == e_data)
          else end_in_failure($sformatf("Error at %0t: write %h=%h, expected %h=%h",
                                        $time, log_addr, log_data, e_addr, e_data));
      end
      if (done_en) begin
        assert (ev_done_q.size() != 0)
          else end_in_failure($sformatf("Error at %0t: extra done for slot %0d",
                                        $time, done_pos));
        take_event();
        assert (e_done)
          else end_in_failure($sformatf("Error at %0t: early done for slot %0d",
                                        $time, done_pos));
        assert (done_pos == e_id)
          else end_in_failure($sformatf("Error at %0t: done_pos %0d, expected %0d",
                                        $time, done_pos, e_id));
      end
      prev_stall  = (htrans != HTRANS_IDLE) && !hready;
      prev_haddr  = haddr;
      prev_htrans = htrans;
      prev_hburst = hburst;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    seed_draw  = $urandom(SEED);
    clk        = 1'b0;
    rst        = 1'b1;
    noc_flit   = '0;
    noc_valid  = 1'b0;
    slow       = 1'b0;
    gaps_on    = 1'b1;
    saw_full   = 1'b0;
    prev_stall = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // Idle bus right after reset
    repeat (2) begin
      @(posedge clk);
      #1;
      assert (!done_en && htrans == HTRANS_IDLE && !hsel)
        else end_in_failure($sformatf("Error at %0t: bus or done_en active after reset", $time));
    end
    send_r2l(2'd0, 1'b1, 32'h0000_1000, 4);
    send_r2l(2'd1, 1'b0, 32'h0000_2000, 3);
    send_r2l(2'd1, 1'b1, 32'h0000_2010, 1);
    // Ack straight behind a write packet
    send_l2r(2'd2);
    // Unknown type is dropped
    drive_flit(header_flit(FLIT_SINGLE, PKT_OTHER, 2'd3, 1'b1));
    send_l2r(2'd3);
    for (i = 0; i < 8; i++) begin
      if ($urandom % 4 == 0) begin
        send_l2r(slot_id_t'($urandom % 4));
      end else begin
        send_r2l(slot_id_t'($urandom % 4), 1'(($urandom % 2)), addr_t'($urandom & 32'h000f_fffc),
                 1 + int'($urandom % 8));
      end
    end
    wait_drained();
    // Heavy wait states and no gaps to fill the buffer
    slow    = 1'b1;
    gaps_on = 1'b0;
    for (i = 0; i < 4; i++) begin
      send_r2l(slot_id_t'(i), 1'b1, 32'h0004_0000 + addr_t'(i * 256), 12);
    end
    send_l2r(2'd0);
    wait_drained();
    slow = 1'b0;
    // Quiet period for stray writes or completions
    repeat (20) @(posedge clk);
    if (saw_full) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      end_in_failure("Back-pressure never reached the NoC input, noc_ready stayed high");
    end
  end

endmodule

// File: sources.f
+incdir+hdl
hdl/dma_noc_pkg.sv
hdl/dma_bus_pkg.sv
hdl/dma_packet_buffer.sv
hdl/dma_resp_parser.sv
hdl/dma_ahb_writer.sv
hdl/dma_resp_top.sv
tests/dma_ahb_mem_model.sv
tests/tb_dma_resp.sv

// File: Makefile
# Verilator build, run, lint and clean for the DMA receive path

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
TOP        ?= tb_dma_resp
RTL_TOP    ?= dma_resp_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Nonzero exit status on failure
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
